// File: design/block_ram.sv
// inferred dual-port word ram
// port a read/write, port b read only, one cycle read latency
`timescale 1ns/1ps

module block_ram import jpeg_pkg::*; #(
    parameter int DEPTH_WORDS = 16
) (
    input  logic                           wb_clk_i,
    input  logic                           a_en_i,
    input  logic                           a_we_i,
    input  logic [$clog2(DEPTH_WORDS)-1:0] a_adr_i,
    input  mem_word_u                      a_dat_i,
    input  logic [$clog2(DEPTH_WORDS)-1:0] b_adr_i,
    output mem_word_u                      a_dat_o,
    output mem_word_u                      b_dat_o
);

    mem_word_u mem [DEPTH_WORDS];

    // port a, read before write
    always_ff @(posedge wb_clk_i) begin
        if (a_en_i) begin
            if (a_we_i) begin
                mem[a_adr_i] <= a_dat_i;
            end
            a_dat_o <= mem[a_adr_i];
        end
    end

    // port b
    always_ff @(posedge wb_clk_i) begin
        b_dat_o <= mem[b_adr_i];
    end

endmodule

// File: design/dct8.sv
// registered 8-point one-dimensional dct
// pixel rows in the row pass, transpose columns in the column pass
`timescale 1ns/1ps
`include "jpeg_params.svh"

module dct8 import jpeg_pkg::*; (
    input  logic                          wb_clk_i,
    input  logic                          en_i,
    input  seq_ctrl_t                     ctrl_i,
    input  mem_word_u                     row_lo_i,
    input  mem_word_u                     row_hi_i,
    input  logic [0:7][`JPEG_ROW_W-1:0]  col_i,
    output logic [0:7][`JPEG_COEF_W-1:0] y_o
);

    // round(2048 * c(k)/2 * cos((2n+1)k*pi/16)), row k, column n
    localparam logic signed [11:0] COS [8][8] = '{
        '{ 724,   724,   724,   724,   724,   724,   724,   724},
        '{1004,   851,   569,   200,  -200,  -569,  -851, -1004},
        '{ 946,   392,  -392,  -946,  -946,  -392,   392,   946},
        '{ 851,  -200, -1004,  -569,   569,  1004,   200,  -851},
        '{ 724,  -724,  -724,   724,   724,  -724,  -724,   724},
        '{ 569, -1004,   200,   851,  -851,  -200,  1004,  -569},
        '{ 392,  -946,   946,  -392,  -392,   946,  -946,   392},
        '{ 200,  -569,   851, -1004,  1004,  -851,   569,  -200}
    };

    mem_word_u                     lo_q;
    logic signed [`JPEG_ROW_W-1:0] x [8];
    logic signed [31:0]            acc;
    logic [0:7][`JPEG_COEF_W-1:0] y_d;

    // first word of a row arrives one clock ahead of the second
    always_ff @(posedge wb_clk_i) begin
        if (!en_i) begin
            lo_q <= row_lo_i;
        end
    end

    // input select, pixels sign extended
    always_comb begin
        if (ctrl_i.col_pass) begin
            for (int n = 0; n < 8; n++) begin
                x[n] = col_i[n];
            end
        end else begin
            for (int n = 0; n < 4; n++) begin
                x[n]     = $signed(lo_q.pix[n]);
                x[n + 4] = $signed(row_hi_i.pix[n]);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sum of products, scaled back by the cosine fraction
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        acc = '0;
        for (int k = 0; k < 8; k++) begin
            acc = '0;
            for (int n = 0; n < 8; n++) begin
                acc = acc + x[n] * COS[k][n];
            end
            // arithmetic shift, keep coefficient width
            y_d[k] = acc[`JPEG_DCT_SHIFT +: `JPEG_COEF_W];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (en_i) begin
            y_o <= y_d;
        end
    end

endmodule

// File: design/dct_sequencer.sv
// block schedule of the transform
// rows through the dct into the transpose memory
// then columns through the dct into the quantizer
`timescale 1ns/1ps
`include "jpeg_params.svh"

module dct_sequencer import jpeg_pkg::*; (
    input  logic                               wb_clk_i,
    input  logic                               rst_n_i,
    input  logic                               start_i,
    output logic [$clog2(`JPEG_IN_WORDS)-1:0] in_adr_o,
    output seq_ctrl_t                          ctrl_o,
    output logic                               done_o
);

    localparam logic [1:0] PH_IDLE = 2'd0;
    localparam logic [1:0] PH_ROW  = 2'd1;
    localparam logic [1:0] PH_COL  = 2'd2;
    localparam logic [1:0] PH_DONE = 2'd3;
    // last transpose write of the row phase
    localparam logic [4:0] ROW_LAST = 5'd17;

    logic [1:0] phase_q;
    logic [4:0] cnt_q;
    logic [2:0] col_q;
    logic [2:0] step_q;
    logic [4:0] wr_row;

    //////////////////////////////////////////////////////////////////////
    // phase and cycle counters
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_q <= PH_IDLE;
            cnt_q   <= '0;
            col_q   <= '0;
            step_q  <= '0;
        end else begin
            case (phase_q)
                PH_IDLE: begin
                    if (start_i) begin
                        phase_q <= PH_ROW;
                        cnt_q   <= '0;
                        col_q   <= '0;
                        step_q  <= '0;
                    end
                end
                PH_ROW: begin
                    if (cnt_q == ROW_LAST) begin
                        phase_q <= PH_COL;
                    end else begin
                        cnt_q <= cnt_q + 5'd1;
                    end
                end
                PH_COL: begin
                    // read step plus four lane steps per column
                    if (step_q == 3'd4) begin
                        step_q <= '0;
                        col_q  <= col_q + 3'd1;
                        if (col_q == 3'd7) begin
                            phase_q <= PH_DONE;
                        end
                    end else begin
                        step_q <= step_q + 3'd1;
                    end
                end
                default: phase_q <= PH_IDLE;
            endcase
        end
    end

    // last output word is written while done is high
    assign done_o = (phase_q == PH_DONE);

    //////////////////////////////////////////////////////////////////////
    // control decode
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        ctrl_o   = '0;
        // word 2r at even count, word 2r+1 one clock later
        in_adr_o = cnt_q[3:0];
        wr_row   = cnt_q - 5'd3;
        case (phase_q)
            PH_ROW: begin
                // hi word of row r arrives at count 2r+2
                ctrl_o.dct_en = !cnt_q[0] && (cnt_q >= 5'd2) && (cnt_q <= 5'd16);
                // its result is written one clock later
                ctrl_o.t_wr   = cnt_q[0] && (cnt_q >= 5'd3);
                ctrl_o.idx    = wr_row[3:1];
            end
            PH_COL: begin
                ctrl_o.col_pass = 1'b1;
                ctrl_o.idx      = col_q;
                ctrl_o.t_rd     = (step_q == 3'd0);
                ctrl_o.dct_en   = (step_q == 3'd0);
                ctrl_o.out_we   = (step_q != 3'd0);
                ctrl_o.lane     = 2'(step_q - 3'd1);
            end
            default: begin
                ctrl_o = '0;
            end
        endcase
    end

    // a row write follows its row dct by one clock and never meets a read
    twr_trd_excl: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        ctrl_o.t_wr |-> !ctrl_o.t_rd && $past(ctrl_o.dct_en));

endmodule

// File: design/jpeg_bus_port.sv
// wishbone slave front end of the transform block
// region decode, single-cycle ack, csr and read data mux
`timescale 1ns/1ps
`include "jpeg_params.svh"

module jpeg_bus_port import jpeg_pkg::*; (
    input  logic                    wb_clk_i,
    input  logic                    rst_n_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  logic [`JPEG_ADR_W-1:0]  wb_adr_i,
    input  logic [`JPEG_DATA_W-1:0] wb_dat_i,
    input  mem_word_u               in_rd_i,
    input  mem_word_u               out_rd_i,
    input  logic                    done_i,
    output bus_req_t                req_o,
    output logic                    in_sel_o,
    output logic                    out_sel_o,
    output logic                    start_o,
    output logic                    wb_ack_o,
    output logic [`JPEG_DATA_W-1:0] wb_dat_o
);

    logic [1:0]              region;
    logic                    csr_wr;
    logic                    busy_q;
    logic [`JPEG_DATA_W-1:0] csr_q;

    assign region    = wb_adr_i[`JPEG_REGION_HI:`JPEG_REGION_LO];
    assign in_sel_o  = wb_stb_i && (region == `JPEG_REG_IN);
    assign out_sel_o = wb_stb_i && (region == `JPEG_REG_OUT);
    // csr takes the write once, in the acknowledged cycle
    assign csr_wr    = wb_stb_i && wb_we_i && wb_ack_o && (region == `JPEG_REG_CSR);

    assign req_o = '{stb: wb_stb_i, we: wb_we_i, adr: wb_adr_i, dat: wb_dat_i};

    // ack one clock after strobe, held for a single cycle
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= wb_stb_i && !wb_ack_o;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // control/status register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            start_o <= 1'b0;
            csr_q   <= '0;
        end else begin
            start_o <= 1'b0;
            if (done_i) begin
                busy_q <= 1'b0;
                csr_q  <= `JPEG_CSR_DONE;
            end else if (csr_wr && !busy_q) begin
                if (wb_dat_i == `JPEG_CSR_START) begin
                    // block starts, csr reads zero until done
                    busy_q  <= 1'b1;
                    start_o <= 1'b1;
                    csr_q   <= '0;
                end else begin
                    csr_q <= wb_dat_i;
                end
            end
        end
    end

    // read data, valid while ack is high
    always_comb begin
        case (region)
            `JPEG_REG_IN:  wb_dat_o = in_rd_i;
            `JPEG_REG_OUT: wb_dat_o = out_rd_i;
            `JPEG_REG_CSR: wb_dat_o = csr_q;
            default:       wb_dat_o = '0;
        endcase
    end

    // every ack answers a strobe still held on the same address
    ack_has_stb: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        wb_ack_o |-> $past(wb_stb_i) && wb_stb_i && $stable(wb_adr_i));

endmodule

// File: design/jpeg_params.svh
// address map, buffer depths and datapath widths
// fixed-point shifts for the dct and the quantizer
`ifndef JPEG_PARAMS_SVH
`define JPEG_PARAMS_SVH

// wishbone bus
`define JPEG_DATA_W     32
`define JPEG_ADR_W      13

// region select bits of the word address
`define JPEG_REGION_HI  12
`define JPEG_REGION_LO  11
`define JPEG_REG_IN     2'd0
`define JPEG_REG_OUT    2'd1
`define JPEG_REG_CSR    2'd2

// four pixels per input word, two coefficients per output word
`define JPEG_IN_WORDS   16
`define JPEG_OUT_WORDS  32

// datapath widths
`define JPEG_ROW_W      12
`define JPEG_COEF_W     16

// fractional bits of cosines and reciprocals
`define JPEG_DCT_SHIFT  11
`define JPEG_Q_SHIFT    16

// csr values
`define JPEG_CSR_START  1
`define JPEG_CSR_DONE   128

`endif

// File: design/jpeg_pkg.sv
// shared types of the jpeg transform block
// bus request, sequencer control word, buffer word and quant table
`include "jpeg_params.svh"

package jpeg_pkg;

    // one wishbone request as seen by the buffers
    typedef struct packed {
        logic                    stb;
        logic                    we;
        logic [`JPEG_ADR_W-1:0]  adr;
        logic [`JPEG_DATA_W-1:0] dat;
    } bus_req_t;

    // per-cycle datapath control from the sequencer
    typedef struct packed {
        logic       dct_en;
        logic       col_pass;
        logic       t_wr;
        logic       t_rd;
        // row on write, column on read and quantize
        logic [2:0] idx;
        logic [1:0] lane;
        logic       out_we;
    } seq_ctrl_t;

    // buffer word, first element in the top bits
    typedef union packed {
        logic [0:3][7:0]               pix;
        logic [0:1][`JPEG_COEF_W-1:0] coef;
    } mem_word_u;

    //////////////////////////////////////////////////////////////////////
    // reciprocal quantization table, 16 fractional bits, index 8u+v
    //////////////////////////////////////////////////////////////////////
    localparam logic [15:0] RECIP [64] = '{
        16'd2048, 16'd2979, 16'd3277, 16'd2048, 16'd1365, 16'd819,  16'd643,  16'd537,
        16'd2731, 16'd2731, 16'd2341, 16'd1725, 16'd1260, 16'd565,  16'd546,  16'd596,
        16'd2341, 16'd2521, 16'd2048, 16'd1365, 16'd819,  16'd575,  16'd475,  16'd585,
        16'd2341, 16'd1928, 16'd1489, 16'd1130, 16'd643,  16'd377,  16'd410,  16'd529,
        16'd1820, 16'd1489, 16'd886,  16'd585,  16'd482,  16'd301,  16'd318,  16'd426,
        16'd1365, 16'd936,  16'd596,  16'd512,  16'd405,  16'd315,  16'd290,  16'd356,
        16'd669,  16'd512,  16'd420,  16'd377,  16'd318,  16'd271,  16'd273,  16'd324,
        16'd455,  16'd356,  16'd345,  16'd334,  16'd293,  16'd328,  16'd318,  16'd331
    };

endpackage

// File: design/jpeg_top.sv
// top level of the jpeg transform accelerator
// bus port, block buffers, sequencer, dct, transpose and quantizer
`timescale 1ns/1ps
`include "jpeg_params.svh"

module jpeg_top import jpeg_pkg::*; (
    input  logic                    wb_clk_i,
    input  logic                    rst_n_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  logic [`JPEG_ADR_W-1:0]  wb_adr_i,
    input  logic [`JPEG_DATA_W-1:0] wb_dat_i,
    output logic [`JPEG_DATA_W-1:0] wb_dat_o,
    output logic                    wb_ack_o
);

    localparam int IN_AW  = $clog2(`JPEG_IN_WORDS);
    localparam int OUT_AW = $clog2(`JPEG_OUT_WORDS);

    bus_req_t                     req;
    logic                         in_sel;
    logic                         start;
    logic                         done;
    mem_word_u                    in_rd_a;
    mem_word_u                    in_rd_b;
    mem_word_u                    out_rd_b;
    logic [IN_AW-1:0]             in_adr;
    seq_ctrl_t                    ctrl;
    logic [0:7][`JPEG_COEF_W-1:0] y;
    logic [0:7][`JPEG_ROW_W-1:0]  y_row;
    logic [0:7][`JPEG_ROW_W-1:0]  col;
    logic                         out_we;
    logic [OUT_AW-1:0]            out_adr;
    mem_word_u                    out_wr;

    // row results enter the transpose memory truncated
    for (genvar i = 0; i < 8; i++) begin : g_row
        assign y_row[i] = y[i][`JPEG_ROW_W-1:0];
    end

    //////////////////////////////////////////////////////////////////////
    // bus side
    //////////////////////////////////////////////////////////////////////
    jpeg_bus_port u_bus_port (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .in_rd_i  (in_rd_a),
        .out_rd_i (out_rd_b),
        .done_i   (done),
        .req_o    (req),
        .in_sel_o (in_sel),
        .out_sel_o(),
        .start_o  (start),
        .wb_ack_o (wb_ack_o),
        .wb_dat_o (wb_dat_o)
    );

    // input buffer, bus on port a, sequencer reads on port b
    block_ram #(.DEPTH_WORDS(`JPEG_IN_WORDS)) u_in_buf (
        .wb_clk_i(wb_clk_i),
        .a_en_i  (in_sel),
        .a_we_i  (req.we),
        .a_adr_i (req.adr[IN_AW-1:0]),
        .a_dat_i (req.dat),
        .b_adr_i (in_adr),
        .a_dat_o (in_rd_a),
        .b_dat_o (in_rd_b)
    );

    // output buffer, quantizer writes on port a, bus reads on port b
    block_ram #(.DEPTH_WORDS(`JPEG_OUT_WORDS)) u_out_buf (
        .wb_clk_i(wb_clk_i),
        .a_en_i  (out_we),
        .a_we_i  (out_we),
        .a_adr_i (out_adr),
        .a_dat_i (out_wr),
        .b_adr_i (req.adr[OUT_AW-1:0]),
        .a_dat_o (),
        .b_dat_o (out_rd_b)
    );

    //////////////////////////////////////////////////////////////////////
    // transform datapath
    //////////////////////////////////////////////////////////////////////
    dct_sequencer u_seq (
        .wb_clk_i(wb_clk_i),
        .rst_n_i (rst_n_i),
        .start_i (start),
        .in_adr_o(in_adr),
        .ctrl_o  (ctrl),
        .done_o  (done)
    );

    // both row words come off port b on consecutive clocks
    dct8 u_dct (
        .wb_clk_i(wb_clk_i),
        .en_i    (ctrl.dct_en),
        .ctrl_i  (ctrl),
        .row_lo_i(in_rd_b),
        .row_hi_i(in_rd_b),
        .col_i   (col),
        .y_o     (y)
    );

    transpose_mem u_tmem (
        .wb_clk_i(wb_clk_i),
        .rst_n_i (rst_n_i),
        .ctrl_i  (ctrl),
        .row_i   (y_row),
        .col_o   (col)
    );

    quantizer u_quant (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .ctrl_i   (ctrl),
        .y_i      (y),
        .out_we_o (out_we),
        .out_adr_o(out_adr),
        .out_dat_o(out_wr)
    );

endmodule

// File: design/quantizer.sv
// two-lane reciprocal quantizer
// packs coefficients u=2l and 2l+1 of column v into one output word
`timescale 1ns/1ps
`include "jpeg_params.svh"

module quantizer import jpeg_pkg::*; (
    input  logic                                wb_clk_i,
    input  logic                                rst_n_i,
    input  seq_ctrl_t                           ctrl_i,
    input  logic [0:7][`JPEG_COEF_W-1:0]       y_i,
    output logic                                out_we_o,
    output logic [$clog2(`JPEG_OUT_WORDS)-1:0] out_adr_o,
    output mem_word_u                           out_dat_o
);

    logic [2:0]         u0;
    logic [2:0]         u1;
    logic [15:0]        rec0;
    logic [15:0]        rec1;
    logic signed [32:0] prod0;
    logic signed [32:0] prod1;

    // lane l covers rows 2l and 2l+1 of the current column
    always_comb begin
        u0    = {ctrl_i.lane, 1'b0};
        u1    = {ctrl_i.lane, 1'b1};
        rec0  = RECIP[{u0, ctrl_i.idx}];
        rec1  = RECIP[{u1, ctrl_i.idx}];
        prod0 = $signed(y_i[u0]) * $signed({1'b0, rec0});
        prod1 = $signed(y_i[u1]) * $signed({1'b0, rec1});
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_we_o <= 1'b0;
        end else begin
            out_we_o <= ctrl_i.out_we;
        end
    end

    // word 4v+l, lower u in the top half
    always_ff @(posedge wb_clk_i) begin
        if (ctrl_i.out_we) begin
            out_adr_o         <= {ctrl_i.idx, ctrl_i.lane};
            out_dat_o.coef[0] <= prod0[`JPEG_Q_SHIFT +: `JPEG_COEF_W];
            out_dat_o.coef[1] <= prod1[`JPEG_Q_SHIFT +: `JPEG_COEF_W];
        end
    end

endmodule

// File: design/transpose_mem.sv
// 8x8 transpose register array
// written a row at a time, read a column at a time
`timescale 1ns/1ps
`include "jpeg_params.svh"

module transpose_mem import jpeg_pkg::*; (
    input  logic                         wb_clk_i,
    input  logic                         rst_n_i,
    input  seq_ctrl_t                    ctrl_i,
    input  logic [0:7][`JPEG_ROW_W-1:0] row_i,
    output logic [0:7][`JPEG_ROW_W-1:0] col_o
);

    // mem_q[r][j] is row r, column j
    logic [0:7][0:7][`JPEG_ROW_W-1:0] mem_q;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_q <= '0;
        end else if (ctrl_i.t_wr) begin
            mem_q[ctrl_i.idx] <= row_i;
        end
    end

    // column j is element j of every row
    always_comb begin
        for (int r = 0; r < 8; r++) begin
            col_o[r] = ctrl_i.t_rd ? mem_q[r][ctrl_i.idx] : '0;
        end
    end

endmodule

// File: list.f
+incdir+design
+incdir+test
design/jpeg_pkg.sv
design/jpeg_bus_port.sv
design/block_ram.sv
design/dct_sequencer.sv
design/dct8.sv
design/transpose_mem.sv
design/quantizer.sv
design/jpeg_top.sv
test/jpeg_tb.sv

// File: test/jpeg_ref.svh
// reference model of the quantized two-dimensional dct
// row pass, 12-bit transpose, column pass and reciprocal scaling
`ifndef JPEG_REF_SVH
`define JPEG_REF_SVH

localparam real PI = 3.14159265358979;

// round(2048 * c(k)/2 * cos((2n+1)k*pi/16)), nearest, ties away from zero
function automatic int cos_coef(input int k, input int n);
    real ck;
    real v;
    ck = (k == 0) ? 1.0 / $sqrt(2.0) : 1.0;
    v  = 2048.0 * ck / 2.0 * $cos((2 * n + 1) * k * PI / 16.0);
    if (v >= 0.0) begin
        return $rtoi(v + 0.5);
    end else begin
        return -$rtoi(-v + 0.5);
    end
endfunction

// pixel[] in, exp_word[] out
task automatic build_expected();
    int                 c [8][8];
    int                 rowres [8][8];
    int                 s;
    longint             prod;
    logic signed [11:0] t12;
    logic signed [15:0] f16;
    logic [15:0]        q [8][8];
    for (int k = 0; k < 8; k++) begin
        for (int n = 0; n < 8; n++) begin
            c[k][n] = cos_coef(k, n);
        end
    end
    // row pass, only the low 12 bits reach the transpose
    for (int r = 0; r < 8; r++) begin
        for (int k = 0; k < 8; k++) begin
            s = 0;
            for (int n = 0; n < 8; n++) begin
                s = s + pixel[8 * r + n] * c[k][n];
            end
            s = s >>> `JPEG_DCT_SHIFT;
            t12 = s[11:0];
            rowres[r][k] = t12;
        end
    end
    // column pass, then reciprocal multiply
    for (int v = 0; v < 8; v++) begin
        for (int u = 0; u < 8; u++) begin
            s = 0;
            for (int n = 0; n < 8; n++) begin
                s = s + rowres[n][v] * c[u][n];
            end
            f16 = 16'(s >>> `JPEG_DCT_SHIFT);
            prod = longint'(f16) * longint'(RECIP[8 * u + v]);
            q[u][v] = 16'(prod >>> `JPEG_Q_SHIFT);
        end
    end
    // word 4v+l holds u=2l on top, u=2l+1 below
    for (int w = 0; w < 32; w++) begin
        exp_word[w] = {q[2 * (w % 4)][w / 4], q[2 * (w % 4) + 1][w / 4]};
    end
endtask

`endif

// File: test/jpeg_tb.sv
// testbench of the jpeg transform accelerator
// wishbone transfers, stimulus table, checks against the reference model
`timescale 1ns/1ps
`include "jpeg_params.svh"

module jpeg_tb import jpeg_pkg::*; ();

    localparam int          CLK_PERIOD  = 8;
    localparam int          RST_CYCLES  = 3;
    localparam int          NUM_CASES   = 10;
    // guard case is the longest, well under this bound
    localparam int          CASE_CYCLES = 1200;
    localparam int          WATCHDOG_NS = (RST_CYCLES + NUM_CASES * CASE_CYCLES) * CLK_PERIOD;
    localparam int          ACK_LIMIT   = 4;
    localparam int          POLL_LIMIT  = 64;
    localparam logic [31:0] SEED        = 32'hdfd6c666;

    localparam logic [2:0] MODE_RW    = 3'd0;
    localparam logic [2:0] MODE_CSR   = 3'd1;
    localparam logic [2:0] MODE_CONST = 3'd2;
    localparam logic [2:0] MODE_RAND  = 3'd3;
    localparam logic [2:0] MODE_GUARD = 3'd4;

    // one row of the stimulus table
    typedef struct packed {
        logic [2:0]  mode;
        logic [7:0]  seed_off;
        logic [7:0]  fill;
        logic [31:0] exp_csr;
    } test_case_t;

    logic        wb_clk;
    logic        rst_n;
    logic        wb_stb;
    logic        wb_we;
    logic [12:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    logic [31:0] rng;
    logic [31:0] blk_word [16];
    int          pixel [64];
    logic [31:0] exp_word [32];
    test_case_t  stim_table [NUM_CASES];
    int          err_cnt;

    `include "jpeg_ref.svh"

    jpeg_top u_jpeg_top (
        .wb_clk_i(wb_clk),
        .rst_n_i (rst_n),
        .wb_stb_i(wb_stb),
        .wb_we_i (wb_we),
        .wb_adr_i(wb_adr),
        .wb_dat_i(wb_dat_w),
        .wb_dat_o(wb_dat_r),
        .wb_ack_o(wb_ack)
    );

    initial begin
        wb_clk = 1'b0;
        forever #(CLK_PERIOD / 2) wb_clk = ~wb_clk;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // region code on the top bits, word index below
    function automatic logic [12:0] map_adr(input logic [1:0] rgn, input int idx);
        logic [12:0] a;
        a = '0;
        a[`JPEG_REGION_HI:`JPEG_REGION_LO] = rgn;
        a[4:0] = idx[4:0];
        return a;
    endfunction

    task automatic abort_run(input string why);
        err_cnt++;
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    // one wishbone cycle, driven on the falling edge
    task automatic xfer(input logic we, input logic [12:0] adr,
                        input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        @(negedge wb_clk);
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        @(negedge wb_clk);
        waited = 1;
        while (!wb_ack && waited < ACK_LIMIT) begin
            @(negedge wb_clk);
            waited++;
        end
        if (!wb_ack) begin
            abort_run("bus request was never acknowledged");
        end
        check_value("wb_ack_o latency", 32'(waited), 32'd1);
        rdat = wb_dat_r;
        // strobe held across the ack edge, the csr latches there
        @(negedge wb_clk);
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_word(input logic [12:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        xfer(1'b1, adr, dat, unused);
    endtask

    task automatic read_word(input logic [12:0] adr, output logic [31:0] dat);
        xfer(1'b0, adr, 32'h0, dat);
    endtask

    //////////////////////////////////////////////////////////////////////
    // block level steps
    //////////////////////////////////////////////////////////////////////
    task automatic load_block(input test_case_t tc);
        logic [31:0]       word;
        logic signed [7:0] px;
        rng = SEED + 32'(tc.seed_off);
        for (int w = 0; w < 16; w++) begin
            if (tc.mode == MODE_CONST) begin
                word = {4{tc.fill}};
            end else begin
                rng  = xorshift(rng);
                word = rng;
            end
            blk_word[w] = word;
            // first pixel in the top byte
            for (int j = 0; j < 4; j++) begin
                px = word[31 - 8 * j -: 8];
                pixel[4 * w + j] = px;
            end
            write_word(map_adr(`JPEG_REG_IN, w), word);
        end
        build_expected();
    endtask

    // extra starts land while busy
    task automatic start_block(input int count);
        logic [31:0] rd;
        repeat (count) write_word(map_adr(`JPEG_REG_CSR, 0), `JPEG_CSR_START);
        read_word(map_adr(`JPEG_REG_CSR, 0), rd);
        check_value("csr while running", rd, 32'd0);
    endtask

    task automatic await_done();
        logic [31:0] rd;
        int          polls;
        polls = 0;
        read_word(map_adr(`JPEG_REG_CSR, 0), rd);
        while (rd != `JPEG_CSR_DONE && polls < POLL_LIMIT) begin
            read_word(map_adr(`JPEG_REG_CSR, 0), rd);
            polls++;
        end
        if (rd != `JPEG_CSR_DONE) begin
            abort_run("block never finished, csr did not read the done value");
        end
    endtask

    task automatic check_outputs(input logic dc_only);
        logic [31:0] rd;
        for (int w = 0; w < 32; w++) begin
            read_word(map_adr(`JPEG_REG_OUT, w), rd);
            check_value($sformatf("out_buf[%0d]", w), rd, exp_word[w]);
            // constant block, energy only at f[0][0]
            if (dc_only && w == 0) begin
                check_value("out_buf[0] dc nonzero", 32'(rd[31:16] != 16'h0), 32'd1);
                check_value("out_buf[0] low half", 32'(rd[15:0]), 32'd0);
            end else if (dc_only) begin
                check_value($sformatf("out_buf[%0d] ac", w), rd, 32'd0);
            end
        end
    endtask

    task automatic run_case(input test_case_t tc);
        logic [31:0] rd;
        case (tc.mode)
            MODE_RW: begin
                load_block(tc);
                for (int w = 0; w < 16; w++) begin
                    read_word(map_adr(`JPEG_REG_IN, w), rd);
                    check_value($sformatf("in_buf[%0d]", w), rd, blk_word[w]);
                end
            end
            MODE_CSR: begin
                write_word(map_adr(`JPEG_REG_CSR, 0), {24'h0, tc.fill});
            end
            MODE_CONST, MODE_RAND: begin
                load_block(tc);
                start_block(1);
                await_done();
                check_outputs(tc.mode == MODE_CONST);
            end
            MODE_GUARD: begin
                load_block(tc);
                start_block(2);
                // plain csr writes are dropped while busy
                write_word(map_adr(`JPEG_REG_CSR, 0), {24'h0, tc.fill});
                read_word(map_adr(`JPEG_REG_CSR, 0), rd);
                check_value("csr write while running", rd, 32'd0);
                await_done();
                // output region is read only
                for (int w = 0; w < 32; w++) begin
                    write_word(map_adr(`JPEG_REG_OUT, w), ~exp_word[w]);
                end
                check_outputs(1'b0);
            end
            default: begin
                abort_run("unknown mode in the stimulus table");
            end
        endcase
        read_word(map_adr(`JPEG_REG_CSR, 0), rd);
        check_value("csr", rd, tc.exp_csr);
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus table and main sequence
    //////////////////////////////////////////////////////////////////////
    task automatic init_table();
        // mode, seed offset, fill byte, csr at the end of the case
        stim_table[0] = {MODE_RW,    8'd1, 8'h00, 32'h0000_0000};
        stim_table[1] = {MODE_CSR,   8'd0, 8'h5a, 32'h0000_005a};
        stim_table[2] = {MODE_CONST, 8'd0, 8'h64, 32'h0000_0080};
        stim_table[3] = {MODE_CONST, 8'd0, 8'hb3, 32'h0000_0080};
        stim_table[4] = {MODE_CONST, 8'd0, 8'h80, 32'h0000_0080};
        stim_table[5] = {MODE_CONST, 8'd0, 8'h7f, 32'h0000_0080};
        stim_table[6] = {MODE_RAND,  8'd2, 8'h00, 32'h0000_0080};
        stim_table[7] = {MODE_RAND,  8'd3, 8'h00, 32'h0000_0080};
        stim_table[8] = {MODE_RAND,  8'd4, 8'h00, 32'h0000_0080};
        stim_table[9] = {MODE_GUARD, 8'd5, 8'h3c, 32'h0000_0080};
    endtask

    initial begin
        err_cnt  = 0;
        rst_n    = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        rng      = SEED;
        init_table();
        repeat (RST_CYCLES) @(posedge wb_clk);
        @(negedge wb_clk);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(stim_table[i]);
        end
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        abort_run("timeout, the test cases did not finish in the allowed time");
    end

endmodule
